//--- hdl/rot_pkg.sv
`default_nettype none

package rot_pkg;

  localparam int ROT_RES        = 32;  // Angle steps per revolution
  localparam int HALF_RES       = 16;  // Steps per half turn, angles per bank
  localparam int NUM_RADII      = 8;   // Radial positions per arm
  localparam int DISPLAY_HEIGHT = 16;  // LEDs per column
  localparam int THETA_W        = 5;
  localparam int RADIUS_W       = 3;
  localparam int Z_W            = 4;
  localparam int BANK_DEPTH     = 128; // HALF_RES x NUM_RADII
  localparam int BANK_ADDR_W    = 7;   // {theta mod HALF_RES, radius}

  localparam int RD_LATENCY   = 2; // Column read latency in cycles
  localparam int WRITE_CYCLES = 4; // Read, two latency cycles, OR-write

  localparam logic [1:0] BUF_IDLE  = 2'd0;
  localparam logic [1:0] BUF_FLUSH = 2'd1;
  localparam logic [1:0] BUF_WRITE = 2'd2;

  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;
  localparam logic [AXI_ADDR_W-1:0] REG_VOXEL = 8'h00; // Voxel write
  localparam logic [AXI_ADDR_W-1:0] REG_CTRL  = 8'h04; // Flush and status
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef union packed {
    struct packed {
      logic [19:0]         unused;
      logic [THETA_W-1:0]  theta;  // Bits 11:7
      logic [RADIUS_W-1:0] radius; // Bits 6:4
      logic [Z_W-1:0]      z;      // Bits 3:0
    } voxel;
    struct packed {
      logic [30:0] reserved;
      logic        flush;          // Bit 0
    } ctrl;
  } host_word_u;

endpackage

`default_nettype wire

//--- hdl/single_port_ram.sv
`timescale 1ns/1ns
`default_nettype none

module single_port_ram import rot_pkg::*; (
  input  wire                      clk_in,
  input  wire                      rst_in,
  input  wire  [BANK_ADDR_W-1:0]   addr,
  input  wire  [DISPLAY_HEIGHT-1:0] din,
  input  wire                      we,
  output logic [DISPLAY_HEIGHT-1:0] dout
);

  logic [DISPLAY_HEIGHT-1:0] mem [BANK_DEPTH]; // Column storage
  logic [DISPLAY_HEIGHT-1:0] ram_q;            // Array read stage

  initial begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      mem[i] = '0; // Frame starts dark
    end
  end

  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[addr] <= din;
    end
    ram_q <= mem[addr]; // Old word on a write cycle
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      dout <= '0;
    end else begin
      dout <= ram_q; // Second read stage
    end
  end

endmodule

`default_nettype wire

//--- hdl/rot_frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module rot_frame_buffer import rot_pkg::*; (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       voxel_req,
  input  wire  [THETA_W-1:0]        voxel_theta,
  input  wire  [RADIUS_W-1:0]       voxel_radius,
  input  wire  [Z_W-1:0]            voxel_z,
  input  wire                       flush_req,
  input  wire                       rd_req,
  input  wire  [THETA_W-1:0]        rd_theta,
  input  wire  [RADIUS_W-1:0]       rd_radius,
  output logic                      busy,
  output logic                      rd_ready,
  output logic                      rd_valid,
  output logic [DISPLAY_HEIGHT-1:0] col_near,
  output logic [DISPLAY_HEIGHT-1:0] col_far
);

  logic [1:0]                state;
  logic [BANK_ADDR_W:0]      op_cnt;      // Flush address or write step
  logic [BANK_ADDR_W-1:0]    wr_addr;     // Latched voxel address
  logic                      wr_hi;       // Voxel lives in bank_hi
  logic [DISPLAY_HEIGHT-1:0] wr_bit;      // One-hot z
  logic [DISPLAY_HEIGHT-1:0] new_col;     // Merged column for write-back
  logic                      flush_wr;
  logic                      last_wr;
  logic [BANK_ADDR_W-1:0]    ram_addr;    // Shared by both banks
  logic [DISPLAY_HEIGHT-1:0] ram_din;
  logic                      we_lo;
  logic                      we_hi;
  logic [DISPLAY_HEIGHT-1:0] dout_lo;
  logic [DISPLAY_HEIGHT-1:0] dout_hi;
  logic [RD_LATENCY-1:0]     rd_vld_pipe; // Accepted reads in flight
  logic [RD_LATENCY-1:0]     rd_hi_pipe;  // Near arm in bank_hi

  assign busy     = (state != BUF_IDLE);
  assign rd_ready = (state == BUF_IDLE) && !voxel_req && !flush_req; // Writes win
  assign flush_wr = (state == BUF_FLUSH) && !op_cnt[BANK_ADDR_W];    // Final cycle idles
  assign last_wr  = (state == BUF_WRITE) && (op_cnt == WRITE_CYCLES - 1);

  always_comb begin
    case (state)
      BUF_FLUSH: ram_addr = op_cnt[BANK_ADDR_W-1:0];
      BUF_WRITE: ram_addr = wr_addr;
      default:   ram_addr = {rd_theta[THETA_W-2:0], rd_radius}; // Theta mod HALF_RES
    endcase
  end

  assign ram_din = (state == BUF_FLUSH) ? '0 : new_col;
  assign we_lo   = flush_wr || (last_wr && !wr_hi); // Flush clears both banks
  assign we_hi   = flush_wr || (last_wr && wr_hi);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state  <= BUF_IDLE;
      op_cnt <= '0;
    end else begin
      case (state)
        BUF_IDLE: begin
          op_cnt <= '0;
          if (flush_req) begin
            state <= BUF_FLUSH;
          end else if (voxel_req) begin
            state <= BUF_WRITE;
          end
        end
        BUF_FLUSH: begin
          op_cnt <= op_cnt + 1'b1;
          if (op_cnt == BANK_DEPTH) begin // BANK_DEPTH + 1 busy cycles
            state <= BUF_IDLE;
          end
        end
        BUF_WRITE: begin
          op_cnt <= op_cnt + 1'b1;
          if (op_cnt == WRITE_CYCLES - 1) begin
            state <= BUF_IDLE;
          end
        end
        default: state <= BUF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if ((state == BUF_IDLE) && voxel_req) begin
      wr_addr <= {voxel_theta[THETA_W-2:0], voxel_radius};
      wr_hi   <= voxel_theta[THETA_W-1]; // Upper half turn
      wr_bit  <= DISPLAY_HEIGHT'(1) << voxel_z;
    end
    if ((state == BUF_WRITE) && (op_cnt == WRITE_CYCLES - 2)) begin
      new_col <= (wr_hi ? dout_hi : dout_lo) | wr_bit; // Old column just arrived
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_vld_pipe <= '0;
    end else begin
      rd_vld_pipe <= {rd_vld_pipe[RD_LATENCY-2:0], rd_req && rd_ready};
    end
  end

  always_ff @(posedge clk_in) begin
    rd_hi_pipe <= {rd_hi_pipe[RD_LATENCY-2:0], rd_theta[THETA_W-1]}; // Tracks RAM latency
  end

  assign rd_valid = rd_vld_pipe[RD_LATENCY-1];
  assign col_near = rd_hi_pipe[RD_LATENCY-1] ? dout_hi : dout_lo;
  assign col_far  = rd_hi_pipe[RD_LATENCY-1] ? dout_lo : dout_hi; // Opposite arm

  single_port_ram bank_lo (       // Angles 0 to 15
    .clk_in (clk_in),
    .rst_in (rst_in),
    .addr   (ram_addr),
    .din    (ram_din),
    .we     (we_lo),
    .dout   (dout_lo)
  );

  single_port_ram bank_hi (       // Angles 16 to 31
    .clk_in (clk_in),
    .rst_in (rst_in),
    .addr   (ram_addr),
    .din    (ram_din),
    .we     (we_hi),
    .dout   (dout_hi)
  );

endmodule

`default_nettype wire

//--- hdl/axil_voxel_port.sv
`timescale 1ns/1ns
`default_nettype none

module axil_voxel_port import rot_pkg::*; (
  input  wire                     clk_in,
  input  wire                     rst_in,
  input  wire  [AXI_ADDR_W-1:0]   awaddr,
  input  wire                     awvalid,
  output logic                    awready,
  input  wire  [AXI_DATA_W-1:0]   wdata,
  input  wire  [AXI_DATA_W/8-1:0] wstrb,
  input  wire                     wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  wire                     bready,
  input  wire  [AXI_ADDR_W-1:0]   araddr,
  input  wire                     arvalid,
  output logic                    arready,
  output logic [AXI_DATA_W-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  wire                     rready,
  input  wire                     busy,
  output logic                    voxel_req,
  output logic [THETA_W-1:0]      voxel_theta,
  output logic [RADIUS_W-1:0]     voxel_radius,
  output logic [Z_W-1:0]          voxel_z,
  output logic                    flush_req
);

  host_word_u wword;     // Write data, decoded per address
  logic       wr_accept; // AW and W taken together
  logic       rd_accept;
  logic       hit_voxel;
  logic       hit_ctrl;

  assign wword     = wdata;
  assign wr_accept = awvalid && wvalid && !bvalid && !busy; // One write at a time
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign hit_voxel = (awaddr == REG_VOXEL);
  assign hit_ctrl  = (awaddr == REG_CTRL);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      voxel_req <= 1'b0;
      flush_req <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      voxel_req <= wr_accept && hit_voxel && (&wstrb[1:0]); // Fields span bytes 0 and 1
      flush_req <= wr_accept && hit_ctrl && wstrb[0] && wword.ctrl.flush;
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0; // Held until the master takes it
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_accept) begin
      voxel_theta  <= wword.voxel.theta;
      voxel_radius <= wword.voxel.radius;
      voxel_z      <= wword.voxel.z;
      bresp        <= (hit_voxel || hit_ctrl) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign arready   = !rvalid; // No read response pending
  assign rd_accept = arvalid && arready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rd_accept) begin
      rdata <= '0;
      rresp <= RESP_SLVERR; // Unmapped by default
      if (araddr == REG_CTRL) begin
        rdata <= {{(AXI_DATA_W - 1){1'b0}}, busy}; // Status in bit 0
        rresp <= RESP_OKAY;
      end else if (araddr == REG_VOXEL) begin
        rresp <= RESP_OKAY; // Write-only, reads zero
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/blade_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module blade_scanner import rot_pkg::*; (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       index,
  input  wire                       angle_tick,
  input  wire                       rd_ready,
  input  wire                       rd_valid,
  input  wire  [DISPLAY_HEIGHT-1:0] col_near,
  input  wire  [DISPLAY_HEIGHT-1:0] col_far,
  output logic                      rd_req,
  output logic [THETA_W-1:0]        rd_theta,
  output logic [RADIUS_W-1:0]       rd_radius,
  output logic                      led_valid,
  output logic [THETA_W-1:0]        led_theta,
  output logic [RADIUS_W-1:0]       led_radius,
  output logic [DISPLAY_HEIGHT-1:0] led_near,
  output logic [DISPLAY_HEIGHT-1:0] led_far
);

  logic [THETA_W-1:0]  theta;                  // Current blade angle
  logic [RADIUS_W-1:0] radius;                 // Next radius to fetch
  logic                sweeping;
  logic                restart;
  logic [THETA_W-1:0]  tag_theta  [RD_LATENCY]; // Labels for returning columns
  logic [RADIUS_W-1:0] tag_radius [RD_LATENCY];

  assign restart   = index || angle_tick;
  assign rd_req    = sweeping && rd_ready && !restart; // Old angle is dropped on a tick
  assign rd_theta  = theta;
  assign rd_radius = radius;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      theta    <= '0;
      radius   <= '0;
      sweeping <= 1'b0;
    end else begin
      if (index) begin
        theta <= '0; // Index wins over a tick
      end else if (angle_tick) begin
        theta <= (theta == ROT_RES - 1) ? '0 : theta + 1'b1;
      end
      if (restart) begin
        radius   <= '0;
        sweeping <= 1'b1;
      end else if (rd_req) begin
        radius <= radius + 1'b1;
        if (radius == NUM_RADII - 1) begin
          sweeping <= 1'b0; // Sweep done
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    tag_theta[0]  <= rd_theta;
    tag_radius[0] <= rd_radius;
    for (int i = 1; i < RD_LATENCY; i++) begin
      tag_theta[i]  <= tag_theta[i-1];
      tag_radius[i] <= tag_radius[i-1];
    end
  end

  assign led_valid  = rd_valid;
  assign led_theta  = tag_theta[RD_LATENCY-1];  // Lines up with buffer latency
  assign led_radius = tag_radius[RD_LATENCY-1];
  assign led_near   = col_near;
  assign led_far    = col_far;

endmodule

`default_nettype wire

//--- hdl/pov_display_top.sv
`timescale 1ns/1ns
`default_nettype none

module pov_display_top import rot_pkg::*; (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire  [AXI_ADDR_W-1:0]     awaddr,
  input  wire                       awvalid,
  output logic                      awready,
  input  wire  [AXI_DATA_W-1:0]     wdata,
  input  wire  [AXI_DATA_W/8-1:0]   wstrb,
  input  wire                       wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  wire                       bready,
  input  wire  [AXI_ADDR_W-1:0]     araddr,
  input  wire                       arvalid,
  output logic                      arready,
  output logic [AXI_DATA_W-1:0]     rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  wire                       rready,
  input  wire                       index,
  input  wire                       angle_tick,
  output logic                      led_valid,
  output logic [THETA_W-1:0]        led_theta,
  output logic [RADIUS_W-1:0]       led_radius,
  output logic [DISPLAY_HEIGHT-1:0] led_near,
  output logic [DISPLAY_HEIGHT-1:0] led_far
);

  logic                      busy;         // Buffer operation in progress
  logic                      voxel_req;
  logic [THETA_W-1:0]        voxel_theta;
  logic [RADIUS_W-1:0]       voxel_radius;
  logic [Z_W-1:0]            voxel_z;
  logic                      flush_req;
  logic                      rd_req;       // Scanner column fetch
  logic [THETA_W-1:0]        rd_theta;
  logic [RADIUS_W-1:0]       rd_radius;
  logic                      rd_ready;
  logic                      rd_valid;
  logic [DISPLAY_HEIGHT-1:0] col_near;
  logic [DISPLAY_HEIGHT-1:0] col_far;

  axil_voxel_port  i_port    (.*); // Host side
  rot_frame_buffer i_buffer  (.*);
  blade_scanner    i_scanner (.*); // Blade side

endmodule

`default_nettype wire

//--- test/pov_display_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pov_display_tb import rot_pkg::*; ();

  localparam int WAIT_LIMIT = 300; // Cycles before a wait gives up

  logic                      clk_in;
  logic                      rst_in;
  logic [AXI_ADDR_W-1:0]     awaddr;
  logic [AXI_ADDR_W-1:0]     araddr;
  logic [AXI_DATA_W-1:0]     wdata;
  logic [AXI_DATA_W-1:0]     rdata;
  logic [AXI_DATA_W/8-1:0]   wstrb;
  logic                      awvalid, awready, wvalid, wready, bvalid, bready;
  logic                      arvalid, arready, rvalid, rready;
  logic [1:0]                bresp, rresp;
  logic                      index, angle_tick, led_valid;
  logic [THETA_W-1:0]        led_theta;
  logic [RADIUS_W-1:0]       led_radius;
  logic [DISPLAY_HEIGHT-1:0] led_near, led_far;

  logic [DISPLAY_HEIGHT-1:0] model [ROT_RES][NUM_RADII]; // Reference frame
  logic [DISPLAY_HEIGHT-1:0] got_near [NUM_RADII];        // Columns of the last sweep
  logic [DISPLAY_HEIGHT-1:0] got_far  [NUM_RADII];
  int                        cur_theta;                   // Angle the DUT should hold
  int                        errors;
  int                        timeouts;

  pov_display_top i_dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in; // 4 ns period
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  function automatic logic [31:0] voxel_word(input int theta, input int radius, input int z);
    host_word_u w;
    w              = '0;
    w.voxel.theta  = theta[THETA_W-1:0];
    w.voxel.radius = radius[RADIUS_W-1:0];
    w.voxel.z      = z[Z_W-1:0];
    return w;
  endfunction

  // Waits for the AW/W transfer, then optionally for the response
  task automatic complete_write(input logic take_resp, output logic [1:0] resp);
    int n;
    n = 0;
    @(posedge clk_in);
    while (!awready && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_in);
    end
    if (!awready) report_timeout("awready");
    else if (wready !== 1'b1) report_mismatch("wready", wready, 1); // Rises with awready
    @(negedge clk_in);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp; // Registered at the transfer
    if (take_resp) begin
      n = 0;
      @(posedge clk_in);
      while (!bvalid && n < WAIT_LIMIT) begin
        n++;
        @(posedge clk_in);
      end
      if (!bvalid) report_timeout("bvalid");
      resp = bresp;
      @(negedge clk_in);
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic take_resp, output logic [1:0] resp);
    @(negedge clk_in);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = take_resp; // Low leaves the response pending
    complete_write(take_resp, resp);
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(negedge clk_in);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    @(posedge clk_in);
    while (!arready && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_in);
    end
    if (!arready) report_timeout("arready");
    @(negedge clk_in);
    arvalid = 1'b0;
    n = 0;
    @(posedge clk_in);
    while (!rvalid && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_in);
    end
    if (!rvalid) report_timeout("rvalid");
    else if (arready !== 1'b0) report_mismatch("arready", arready, 0); // Response pending
    data = rdata;
    resp = rresp;
  endtask

  task automatic write_voxel(input int theta, input int radius, input int z);
    logic [1:0] resp;
    axil_write(REG_VOXEL, voxel_word(theta, radius, z), 1'b1, resp);
    if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
    model[theta][radius] = model[theta][radius] | (DISPLAY_HEIGHT'(1) << z);
  endtask

  task automatic wait_idle();
    logic [31:0] data;
    logic [1:0]  resp;
    int          n;
    n = 0;
    axil_read(REG_CTRL, data, resp);
    while (data[0] && n < 200) begin // Busy flag in bit 0
      n++;
      axil_read(REG_CTRL, data, resp);
    end
    if (data[0]) report_timeout("the frame buffer to go idle");
  endtask

  // Collects one sweep at theta and checks both arms against the model
  task automatic collect_sweep(input int theta);
    int n;
    int got;
    int far_theta;
    far_theta = (theta + HALF_RES) % ROT_RES; // Opposite arm
    n   = 0;
    got = 0;
    while (got < NUM_RADII && n < WAIT_LIMIT) begin
      @(negedge clk_in);
      n++;
      if (led_valid) begin
        if (led_theta !== theta) report_mismatch("led_theta", led_theta, theta);
        if (led_radius !== got) report_mismatch("led_radius", led_radius, got);
        if (led_near !== model[theta][got]) report_mismatch("led_near", led_near,
                                                             model[theta][got]);
        if (led_far !== model[far_theta][got]) report_mismatch("led_far", led_far,
                                                                model[far_theta][got]);
        got_near[got] = led_near;
        got_far[got]  = led_far;
        got++;
      end
    end
    if (got < NUM_RADII) report_timeout("a full radius sweep");
    repeat (RD_LATENCY + 2) begin // Nothing more may follow
      @(negedge clk_in);
      if (led_valid) begin
        errors++;
        $display("Extra column delivered after the sweep at theta %0d", theta);
      end
    end
  endtask

  task automatic scan_angle(input int theta);
    if (theta == 0) begin
      @(negedge clk_in);
      index = 1'b1;
      @(negedge clk_in);
      index     = 1'b0;
      cur_theta = 0;
      collect_sweep(0);
    end else begin
      while (cur_theta != theta) begin // Every step on the way is checked too
        @(negedge clk_in);
        angle_tick = 1'b1;
        @(negedge clk_in);
        angle_tick = 1'b0;
        cur_theta  = (cur_theta + 1) % ROT_RES;
        collect_sweep(cur_theta);
      end
    end
  endtask

  task automatic check_frame();
    scan_angle(0);
    scan_angle(ROT_RES - 1);
  endtask

  task automatic scan_after_reset();
    @(negedge clk_in);
    if (bvalid !== 1'b0) report_mismatch("bvalid", bvalid, 0);
    if (rvalid !== 1'b0) report_mismatch("rvalid", rvalid, 0);
    if (awready !== 1'b0) report_mismatch("awready", awready, 0);
    if (wready !== 1'b0) report_mismatch("wready", wready, 0);
    if (led_valid !== 1'b0) report_mismatch("led_valid", led_valid, 0);
    scan_angle(0); // Model is all dark here
  endtask

  task automatic merge_columns();
    write_voxel(3, 2, 5);
    write_voxel(19, 2, 9);
    write_voxel(3, 2, 12);
    scan_angle(3);
    if (got_near[2] !== 16'h1020) report_mismatch("led_near", got_near[2], 16'h1020);
    if (got_far[2] !== 16'h0200) report_mismatch("led_far", got_far[2], 16'h0200);
    scan_angle(19);
    if (got_near[2] !== 16'h0200) report_mismatch("led_near", got_near[2], 16'h0200);
    if (got_far[2] !== 16'h1020) report_mismatch("led_far", got_far[2], 16'h1020);
  endtask

  task automatic random_voxel_fill();
    int theta;
    int radius;
    int z;
    for (int i = 0; i < 40; i++) begin
      if (i % 8 != 7) begin // Every eighth write repeats the last voxel
        theta  = $urandom % ROT_RES;
        radius = $urandom % NUM_RADII;
        z      = $urandom % DISPLAY_HEIGHT;
      end
      write_voxel(theta, radius, z);
    end
    check_frame();
  endtask

  task automatic flush_and_poll();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_write(REG_CTRL, 32'h1, 1'b1, resp);
    if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
    for (int t = 0; t < ROT_RES; t++) begin
      for (int r = 0; r < NUM_RADII; r++) begin
        model[t][r] = '0;
      end
    end
    axil_read(REG_CTRL, data, resp);
    if (data[0] !== 1'b1) report_mismatch("rdata", data, 32'h1); // Flush still running
    if (resp !== RESP_OKAY) report_mismatch("rresp", resp, RESP_OKAY);
    wait_idle();
    check_frame();
  endtask

  task automatic response_backpressure();
    logic [1:0] resp;
    axil_write(REG_VOXEL, voxel_word(7, 1, 3), 1'b0, resp);
    model[7][1] = model[7][1] | 16'h0008;
    repeat (6) begin
      @(negedge clk_in);
      if (bvalid !== 1'b1) report_mismatch("bvalid", bvalid, 1);
      if (bresp !== RESP_OKAY) report_mismatch("bresp", bresp, RESP_OKAY);
    end
    awaddr  = REG_VOXEL;
    wdata   = voxel_word(8, 6, 14);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    repeat (8) begin // Only the pending response blocks a new write
      @(posedge clk_in);
      if (awready !== 1'b0) report_mismatch("awready", awready, 0);
      if (wready !== 1'b0) report_mismatch("wready", wready, 0);
    end
    @(negedge clk_in);
    bready = 1'b1;
    complete_write(1'b1, resp);
    if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
    model[8][6] = model[8][6] | 16'h4000;
    axil_write(8'h08, voxel_word(5, 5, 5), 1'b1, resp); // Unmapped
    if (resp !== RESP_SLVERR) report_mismatch("bresp", resp, RESP_SLVERR);
    wait_idle();
    check_frame();
  endtask

  task automatic voxels_during_scan();
    scan_angle(0);
    fork
      scan_angle(1); // Writes avoid angles 1 and 17
      begin
        write_voxel(5, 0, 1);
        write_voxel(5, 7, 2);
        write_voxel(22, 3, 4);
        write_voxel(12, 4, 15);
      end
    join
    wait_idle();
    check_frame();
  endtask

  initial begin
    void'($urandom(2));
    errors     = 0;
    timeouts   = 0;
    cur_theta  = 0;
    rst_in     = 1'b1;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    wstrb      = '0;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    index      = 1'b0;
    angle_tick = 1'b0;
    for (int t = 0; t < ROT_RES; t++) begin
      for (int r = 0; r < NUM_RADII; r++) begin
        model[t][r] = '0; // RAMs start dark
      end
    end
    repeat (4) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    scan_after_reset();
    merge_columns();
    random_voxel_fill();
    flush_and_poll();
    response_backpressure();
    voxels_during_scan();
    $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hdl/rot_pkg.sv
hdl/single_port_ram.sv
hdl/rot_frame_buffer.sv
hdl/axil_voxel_port.sv
hdl/blade_scanner.sv
hdl/pov_display_top.sv
test/pov_display_tb.sv
